//--- hw/mem_map_params.svh
// ========================================
// Address map and sizes of the memory subsystem
// Include wherever a fixed address or width is needed
// ========================================
`ifndef MEM_MAP_PARAMS_SVH
`define MEM_MAP_PARAMS_SVH

// Data and address width of the core buses
`define XLEN          32

// Shared RAM window, 4096 words from 0x10000
`define RAM_BASE      32'h0001_0000
`define RAM_WORDS     4096
`define RAM_AW        12
// Top 18 address bits all ones select the alias window
`define RAM_ALIAS_TAG 18'h3FFFF

// Debug module area, reached over APB in debug mode
`define DBG_START     32'h0000_0200
`define DBG_END       32'h0000_0FFF
`define APB_AW        13

// Test completion word
`define TOHOST_ADDR   32'h8000_1000

`endif

//--- hw/mem_map_pkg.sv
// ========================================
// Shared types of the memory subsystem
// Referenced by scoped name from every block
// ========================================

`include "mem_map_params.svh"

package mem_map_pkg;

  // One bus word, address or data
  typedef logic [`XLEN-1:0] word_t;

  // Word index into the shared RAM
  typedef logic [`RAM_AW-1:0] ram_addr_t;

  // Byte address on the debug APB
  typedef logic [`APB_AW-1:0] apb_addr_t;

  // Target of a core request
  typedef enum logic [1:0] {
    REGION_NONE   = 2'd0,
    REGION_RAM    = 2'd1,
    REGION_DEBUG  = 2'd2,
    REGION_TOHOST = 2'd3
  } region_e;

endpackage

//--- hw/mem_map_ifs.sv
// ========================================
// Request and response bundles of the shared RAM
// ========================================

`timescale 1ns/1ps

// Decoded RAM requests, levels held while the core holds its request
interface ram_req_if;
  logic                  imem_rd_en;
  mem_map_pkg::ram_addr_t imem_addr;
  logic                  dmem_wr_en;
  logic                  dmem_rd_en;
  mem_map_pkg::ram_addr_t dmem_addr;
  mem_map_pkg::word_t    dmem_wr_data;

  modport decoder (
    output imem_rd_en, imem_addr,
    output dmem_wr_en, dmem_rd_en, dmem_addr, dmem_wr_data
  );

  modport ram (
    input imem_rd_en, imem_addr,
    input dmem_wr_en, dmem_rd_en, dmem_addr, dmem_wr_data
  );
endinterface

// RAM responses, valid and ack are single-cycle pulses
interface ram_rsp_if;
  mem_map_pkg::word_t imem_rd_data;
  logic               imem_valid;
  mem_map_pkg::word_t dmem_rd_data;
  logic               dmem_rd_valid;
  logic               dmem_wr_ack;

  modport ram (
    output imem_rd_data, imem_valid,
    output dmem_rd_data, dmem_rd_valid, dmem_wr_ack
  );

  modport merge (
    input imem_rd_data, imem_valid,
    input dmem_rd_data, dmem_rd_valid, dmem_wr_ack
  );
endinterface

//--- hw/mem_req_decode.sv
// ========================================
// Input side: sorts core requests by region and steers them
// to the shared RAM, the debug APB master or the local responder
// ========================================

`timescale 1ns/1ps

`include "mem_map_params.svh"

module mem_req_decode (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   i_debug_mode,
  input  logic                   i_dbg_idle,
  input  logic                   i_imem_rready,
  input  mem_map_pkg::word_t     i_imem_addr,
  input  logic                   i_dmem_rready,
  input  logic                   i_dmem_wvalid,
  input  mem_map_pkg::word_t     i_dmem_addr,
  input  mem_map_pkg::word_t     i_dmem_wdata,
  ram_req_if.decoder             ram_req,
  output logic                   o_dbg_start,
  output logic                   o_dbg_write,
  output mem_map_pkg::apb_addr_t o_dbg_addr,
  output mem_map_pkg::word_t     o_dbg_wdata,
  output logic                   o_tohost_wr,
  output logic                   o_fault_i,
  output logic                   o_fault_d,
  output mem_map_pkg::word_t     o_wdata
);

  mem_map_pkg::region_e region_i;
  mem_map_pkg::region_e region_d;
  logic                 dmem_req;
  logic                 dbg_req;
  logic                 dbg_pending;

  // ========================================
  // Region and index helpers
  // ========================================

  // Tohost wins, then the debug area, then either RAM window
  function automatic mem_map_pkg::region_e region_of(
    input mem_map_pkg::word_t addr,
    input logic               allow_dbg,
    input logic               allow_tohost
  );
    logic in_ram;
    logic in_dbg;
    in_ram = ((addr >= `RAM_BASE) && (addr <= `RAM_BASE + 4 * `RAM_WORDS - 1)) ||
             (addr[`XLEN-1:`RAM_AW+2] == `RAM_ALIAS_TAG);
    in_dbg = (addr >= `DBG_START) && (addr <= `DBG_END);
    if (allow_tohost && (addr == `TOHOST_ADDR))
      return mem_map_pkg::REGION_TOHOST;
    else if (allow_dbg && in_dbg)
      return mem_map_pkg::REGION_DEBUG;
    else if (in_ram)
      return mem_map_pkg::REGION_RAM;
    else
      return mem_map_pkg::REGION_NONE;
  endfunction

  // Alias addresses keep their low 14 bits and the main window drops the base
  function automatic mem_map_pkg::ram_addr_t ram_index(input mem_map_pkg::word_t addr);
    mem_map_pkg::word_t offset;
    if (addr[`XLEN-1:`RAM_AW+2] == `RAM_ALIAS_TAG)
      offset = {{(`XLEN-`RAM_AW-2){1'b0}}, addr[`RAM_AW+1:0]};
    else
      offset = addr - `RAM_BASE;
    return offset[`RAM_AW+1:2];
  endfunction

  // ========================================
  // Classification
  // ========================================

  // Fetches never reach the debug area and tohost only takes writes
  assign region_i = region_of(i_imem_addr, 1'b0, 1'b0);
  assign region_d = region_of(i_dmem_addr, i_debug_mode, i_dmem_wvalid);
  assign dmem_req = i_dmem_rready || i_dmem_wvalid;

  // RAM requests
  assign ram_req.imem_rd_en   = i_imem_rready && (region_i == mem_map_pkg::REGION_RAM);
  assign ram_req.imem_addr    = ram_index(i_imem_addr);
  assign ram_req.dmem_wr_en   = i_dmem_wvalid && (region_d == mem_map_pkg::REGION_RAM);
  assign ram_req.dmem_rd_en   = i_dmem_rready && (region_d == mem_map_pkg::REGION_RAM);
  assign ram_req.dmem_addr    = ram_index(i_dmem_addr);
  assign ram_req.dmem_wr_data = i_dmem_wdata;

  // ========================================
  // Debug request issue
  // ========================================
  assign dbg_req     = dmem_req && (region_d == mem_map_pkg::REGION_DEBUG);
  assign o_dbg_start = dbg_req && i_dbg_idle && !dbg_pending;
  assign o_dbg_write = i_dmem_wvalid;
  assign o_dbg_addr  = i_dmem_addr[`APB_AW-1:0];
  assign o_dbg_wdata = i_dmem_wdata;

  // Set on issue and cleared once the master is back in idle after answering
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      dbg_pending <= 1'b0;
    else if (o_dbg_start)
      dbg_pending <= 1'b1;
    else if (i_dbg_idle)
      dbg_pending <= 1'b0;
  end

  // Local responder requests
  assign o_tohost_wr = i_dmem_wvalid && (region_d == mem_map_pkg::REGION_TOHOST);
  assign o_fault_i   = i_imem_rready && (region_i == mem_map_pkg::REGION_NONE);
  assign o_fault_d   = dmem_req && (region_d == mem_map_pkg::REGION_NONE);
  assign o_wdata     = i_dmem_wdata;

  // The master leaves idle after every start, so pending clears only after its answer
  a_dbg_start_taken : assert property (@(posedge clk) disable iff (!reset_n)
    o_dbg_start |=> !i_dbg_idle);

endmodule

//--- hw/shared_ram.sv
// ========================================
// Single-port 4096-word RAM shared by fetch and data
// Priority is data write, data read, then instruction read
// ========================================

`timescale 1ns/1ps

`include "mem_map_params.svh"

module shared_ram (
  input  logic clk,
  input  logic reset_n,
  ram_req_if.ram req,
  ram_rsp_if.ram rsp
);

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_DWR,
    GNT_DRD,
    GNT_IRD
  } grant_e;

  mem_map_pkg::word_t     mem [`RAM_WORDS];
  mem_map_pkg::word_t     rd_q;
  mem_map_pkg::ram_addr_t ram_addr;
  grant_e                 grant;
  grant_e                 grant_q;
  logic                   d_busy;
  logic                   i_busy;

  // ========================================
  // Arbiter
  // ========================================

  // A read already in flight is not granted again while the core holds it
  always_comb
  begin
    grant    = GNT_NONE;
    ram_addr = req.imem_addr;
    if (req.dmem_wr_en)
    begin
      grant    = GNT_DWR;
      ram_addr = req.dmem_addr;
    end
    else if (req.dmem_rd_en && !d_busy)
    begin
      grant    = GNT_DRD;
      ram_addr = req.dmem_addr;
    end
    else if (req.imem_rd_en && !i_busy)
      grant = GNT_IRD;
  end

  // Writes always win, so they are acked in the request cycle
  assign rsp.dmem_wr_ack = req.dmem_wr_en;

  // ========================================
  // Array read at the first edge
  // ========================================
  always_ff @(posedge clk)
  begin
    if (grant == GNT_DWR)
      mem[ram_addr] <= req.dmem_wr_data;
    else if (grant != GNT_NONE)
      rd_q <= mem[ram_addr];
  end

  // Grant follows the data by one edge and busy ends once valid has been shown
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      grant_q <= GNT_NONE;
      d_busy  <= 1'b0;
      i_busy  <= 1'b0;
    end
    else
    begin
      grant_q <= grant;
      if (grant == GNT_DRD)
        d_busy <= 1'b1;
      else if (rsp.dmem_rd_valid)
        d_busy <= 1'b0;
      if (grant == GNT_IRD)
        i_busy <= 1'b1;
      else if (rsp.imem_valid)
        i_busy <= 1'b0;
    end
  end

  // ========================================
  // Routing at the second edge
  // ========================================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rsp.imem_valid    <= 1'b0;
      rsp.dmem_rd_valid <= 1'b0;
    end
    else
    begin
      rsp.imem_valid    <= (grant_q == GNT_IRD);
      rsp.dmem_rd_valid <= (grant_q == GNT_DRD);
    end
  end

  always_ff @(posedge clk)
  begin
    if (grant_q == GNT_IRD)
      rsp.imem_rd_data <= rd_q;
    if (grant_q == GNT_DRD)
      rsp.dmem_rd_data <= rd_q;
  end

  // A data read granted at once is answered exactly two cycles later
  a_drd_latency : assert property (@(posedge clk) disable iff (!reset_n)
    req.dmem_rd_en && !req.dmem_wr_en && !d_busy |-> ##2 rsp.dmem_rd_valid);

endmodule

//--- hw/debug_apb_master.sv
// ========================================
// APB master for data accesses to the debug module
// Runs IDLE, SETUP, ACCESS and drops to IDLE outside debug mode
// ========================================

`timescale 1ns/1ps

module debug_apb_master (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   i_debug_mode,
  input  logic                   i_start,
  input  logic                   i_write,
  input  mem_map_pkg::apb_addr_t i_addr,
  input  mem_map_pkg::word_t     i_wdata,
  input  logic                   i_apb_pready,
  input  mem_map_pkg::word_t     i_apb_prdata,
  output mem_map_pkg::apb_addr_t o_apb_paddr,
  output logic                   o_apb_psel,
  output logic                   o_apb_penable,
  output logic                   o_apb_pwrite,
  output mem_map_pkg::word_t     o_apb_pwdata,
  output logic                   o_idle,
  output logic                   o_done_rd,
  output logic                   o_done_wr,
  output mem_map_pkg::word_t     o_rd_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_e;

  apb_state_e             state;
  apb_state_e             state_nxt;
  mem_map_pkg::apb_addr_t addr_q;
  mem_map_pkg::word_t     wdata_q;
  logic                   write_q;
  logic                   finish;

  // Last ACCESS cycle with pready seen
  assign finish = (state == ST_ACCESS) && i_apb_pready;

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (i_start)
          state_nxt = ST_SETUP;
      ST_SETUP:
        state_nxt = ST_ACCESS;
      ST_ACCESS:
        // Wait states just stretch this phase
        if (i_apb_pready)
          state_nxt = ST_IDLE;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state     <= ST_IDLE;
      o_done_rd <= 1'b0;
      o_done_wr <= 1'b0;
    end
    else if (!i_debug_mode)
    begin
      // Leaving debug mode abandons any transfer
      state     <= ST_IDLE;
      o_done_rd <= 1'b0;
      o_done_wr <= 1'b0;
    end
    else
    begin
      state     <= state_nxt;
      o_done_rd <= finish && !write_q;
      o_done_wr <= finish && write_q;
    end
  end

  // Transaction copy keeps the bus stable through ACCESS
  always_ff @(posedge clk)
  begin
    if ((state == ST_IDLE) && i_start)
    begin
      addr_q  <= i_addr;
      wdata_q <= i_wdata;
      write_q <= i_write;
    end
    if (finish && !write_q)
      o_rd_data <= i_apb_prdata;
  end

  // ========================================
  // Bus outputs
  // ========================================
  assign o_apb_psel    = (state != ST_IDLE);
  assign o_apb_penable = (state == ST_ACCESS);
  assign o_apb_paddr   = addr_q;
  assign o_apb_pwrite  = write_q;
  assign o_apb_pwdata  = wdata_q;
  assign o_idle        = (state == ST_IDLE);

  // Address, direction and data hold from SETUP to the end of ACCESS
  a_bus_stable : assert property (@(posedge clk) disable iff (!reset_n)
    o_apb_psel && !(o_apb_penable && i_apb_pready) && i_debug_mode
    |=> o_apb_psel && $stable(o_apb_paddr) && $stable(o_apb_pwrite)
        && $stable(o_apb_pwdata));

endmodule

//--- hw/core_resp_unit.sv
// ========================================
// Output side: merges RAM, APB, tohost and fault answers
// into the core response signals
// ========================================

`timescale 1ns/1ps

module core_resp_unit (
  input  logic               clk,
  input  logic               reset_n,
  ram_rsp_if.merge           rsp,
  input  logic               i_done_rd,
  input  logic               i_done_wr,
  input  mem_map_pkg::word_t i_apb_data,
  input  logic               i_tohost_wr,
  input  logic               i_fault_i,
  input  logic               i_fault_d,
  input  mem_map_pkg::word_t i_wdata,
  output logic               o_imem_rvalid,
  output mem_map_pkg::word_t o_imem_rdata,
  output logic               o_dmem_rvalid,
  output logic               o_dmem_wready,
  output mem_map_pkg::word_t o_dmem_rdata,
  output logic               o_imem_fault,
  output logic               o_dmem_fault,
  output mem_map_pkg::word_t o_tohost
);

  // Fault answers one cycle after the request, then clear while the core lets go
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      o_imem_fault <= 1'b0;
      o_dmem_fault <= 1'b0;
      o_tohost     <= '0;
    end
    else
    begin
      o_imem_fault <= i_fault_i && !o_imem_fault;
      o_dmem_fault <= i_fault_d && !o_dmem_fault;
      if (i_tohost_wr)
        o_tohost <= i_wdata;
    end
  end

  // Fetch side
  assign o_imem_rvalid = rsp.imem_valid || o_imem_fault;
  assign o_imem_rdata  = rsp.imem_valid ? rsp.imem_rd_data : '0;

  // Data fault raises both strobes; the core only watches the one it is waiting on
  assign o_dmem_rvalid = rsp.dmem_rd_valid || i_done_rd || o_dmem_fault;
  assign o_dmem_wready = rsp.dmem_wr_ack || i_done_wr || i_tohost_wr || o_dmem_fault;

  // Zero data unless a read source is answering
  always_comb
  begin
    if (rsp.dmem_rd_valid)
      o_dmem_rdata = rsp.dmem_rd_data;
    else if (i_done_rd)
      o_dmem_rdata = i_apb_data;
    else
      o_dmem_rdata = '0;
  end

endmodule

//--- hw/mem_subsys_top.sv
// ========================================
// Memory subsystem top, core ports and debug APB as plain ports
// ========================================

`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   i_debug_mode,
  // Instruction fetch port
  input  logic                   i_imem_rready,
  input  mem_map_pkg::word_t     i_imem_addr,
  output logic                   o_imem_rvalid,
  output mem_map_pkg::word_t     o_imem_rdata,
  // Data port
  input  logic                   i_dmem_rready,
  input  logic                   i_dmem_wvalid,
  input  mem_map_pkg::word_t     i_dmem_addr,
  input  mem_map_pkg::word_t     i_dmem_wdata,
  output logic                   o_dmem_rvalid,
  output logic                   o_dmem_wready,
  output mem_map_pkg::word_t     o_dmem_rdata,
  // Debug module APB
  output mem_map_pkg::apb_addr_t o_apb_paddr,
  output logic                   o_apb_psel,
  output logic                   o_apb_penable,
  output logic                   o_apb_pwrite,
  output mem_map_pkg::word_t     o_apb_pwdata,
  input  logic                   i_apb_pready,
  input  mem_map_pkg::word_t     i_apb_prdata,
  // Status
  output logic                   o_imem_fault,
  output logic                   o_dmem_fault,
  output mem_map_pkg::word_t     o_tohost
);

  logic                   dbg_start;
  logic                   dbg_write;
  mem_map_pkg::apb_addr_t dbg_addr;
  mem_map_pkg::word_t     dbg_wdata;
  logic                   dbg_idle;
  logic                   done_rd;
  logic                   done_wr;
  mem_map_pkg::word_t     apb_rd_data;
  logic                   tohost_wr;
  logic                   fault_i;
  logic                   fault_d;
  mem_map_pkg::word_t     wdata;

  ram_req_if u_ram_req ();
  ram_rsp_if u_ram_rsp ();

  mem_req_decode u_decode (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (i_debug_mode),
    .i_dbg_idle    (dbg_idle),
    .i_imem_rready (i_imem_rready),
    .i_imem_addr   (i_imem_addr),
    .i_dmem_rready (i_dmem_rready),
    .i_dmem_wvalid (i_dmem_wvalid),
    .i_dmem_addr   (i_dmem_addr),
    .i_dmem_wdata  (i_dmem_wdata),
    .ram_req       (u_ram_req.decoder),
    .o_dbg_start   (dbg_start),
    .o_dbg_write   (dbg_write),
    .o_dbg_addr    (dbg_addr),
    .o_dbg_wdata   (dbg_wdata),
    .o_tohost_wr   (tohost_wr),
    .o_fault_i     (fault_i),
    .o_fault_d     (fault_d),
    .o_wdata       (wdata)
  );

  shared_ram u_ram (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (u_ram_req.ram),
    .rsp     (u_ram_rsp.ram)
  );

  debug_apb_master u_apb (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (i_debug_mode),
    .i_start       (dbg_start),
    .i_write       (dbg_write),
    .i_addr        (dbg_addr),
    .i_wdata       (dbg_wdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata),
    .o_idle        (dbg_idle),
    .o_done_rd     (done_rd),
    .o_done_wr     (done_wr),
    .o_rd_data     (apb_rd_data)
  );

  core_resp_unit u_resp (
    .clk           (clk),
    .reset_n       (reset_n),
    .rsp           (u_ram_rsp.merge),
    .i_done_rd     (done_rd),
    .i_done_wr     (done_wr),
    .i_apb_data    (apb_rd_data),
    .i_tohost_wr   (tohost_wr),
    .i_fault_i     (fault_i),
    .i_fault_d     (fault_d),
    .i_wdata       (wdata),
    .o_imem_rvalid (o_imem_rvalid),
    .o_imem_rdata  (o_imem_rdata),
    .o_dmem_rvalid (o_dmem_rvalid),
    .o_dmem_wready (o_dmem_wready),
    .o_dmem_rdata  (o_dmem_rdata),
    .o_imem_fault  (o_imem_fault),
    .o_dmem_fault  (o_dmem_fault),
    .o_tohost      (o_tohost)
  );

endmodule

//--- tb/tb_clk_gen.sv
// ========================================
// Testbench clock of 20 ns and active-low reset
// ========================================

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset_n
);

  // Free-running clock
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset released on a rising edge after the hold time
  initial
  begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

//--- tb/tb_mem_subsys.sv
// ========================================
// Table-driven testbench of the memory subsystem
// Plays the core ports and a slow APB debug slave
// ========================================

`timescale 1ns/1ps

`include "mem_map_params.svh"

module tb_mem_subsys;

  localparam int RESET_CYCLES = 8;
  localparam int NROWS        = 12;
  // Row port selection
  localparam int P_DATA = 0;
  localparam int P_INST = 1;
  localparam int P_BOTH = 2;

  logic        clk;
  logic        reset_n;
  logic        i_debug_mode;
  logic        i_imem_rready;
  logic [31:0] i_imem_addr;
  logic        o_imem_rvalid;
  logic [31:0] o_imem_rdata;
  logic        i_dmem_rready;
  logic        i_dmem_wvalid;
  logic [31:0] i_dmem_addr;
  logic [31:0] i_dmem_wdata;
  logic        o_dmem_rvalid;
  logic        o_dmem_wready;
  logic [31:0] o_dmem_rdata;
  logic [12:0] o_apb_paddr;
  logic        o_apb_psel;
  logic        o_apb_penable;
  logic        o_apb_pwrite;
  logic [31:0] o_apb_pwdata;
  logic        i_apb_pready;
  logic [31:0] i_apb_prdata;
  logic        o_imem_fault;
  logic        o_dmem_fault;
  logic [31:0] o_tohost;

  // ========================================
  // Stimulus table with one entry per operation
  // ========================================
  string       row_name [NROWS];
  int          row_port [NROWS];
  bit          row_wr [NROWS];
  bit          row_dbg [NROWS];
  logic [31:0] row_daddr [NROWS];
  logic [31:0] row_iaddr [NROWS];
  logic [31:0] row_wdata [NROWS];
  logic [31:0] row_exp_d [NROWS];
  logic [31:0] row_exp_i [NROWS];
  bit          row_fault [NROWS];
  int          row_lat [NROWS];
  bit          row_apb [NROWS];
  bit          row_tohost [NROWS];
  int          nrows;

  // Expected contents of the RAM words followed by the 16 APB slave words
  logic [31:0] model [`RAM_WORDS + 16];
  logic [31:0] rng_state;

  // APB slave state
  logic [31:0] apb_mem [16];
  logic        setup_seen;
  int          wait_cnt;
  logic [12:0] last_paddr;
  logic        last_pwrite;
  logic [31:0] last_pwdata;

  int checks;
  int row_errs;
  int total_errs;
  int apb_errs;
  int cycle_cnt;
  int limit;

  tb_clk_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clk (
    .clk     (clk),
    .reset_n (reset_n)
  );

  mem_subsys_top u_dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (i_debug_mode),
    .i_imem_rready (i_imem_rready),
    .i_imem_addr   (i_imem_addr),
    .o_imem_rvalid (o_imem_rvalid),
    .o_imem_rdata  (o_imem_rdata),
    .i_dmem_rready (i_dmem_rready),
    .i_dmem_wvalid (i_dmem_wvalid),
    .i_dmem_addr   (i_dmem_addr),
    .i_dmem_wdata  (i_dmem_wdata),
    .o_dmem_rvalid (o_dmem_rvalid),
    .o_dmem_wready (o_dmem_wready),
    .o_dmem_rdata  (o_dmem_rdata),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata),
    .o_imem_fault  (o_imem_fault),
    .o_dmem_fault  (o_dmem_fault),
    .o_tohost      (o_tohost)
  );

  // 32-bit xorshift for write data
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Model slot of an address in the RAM window, its alias or the APB slave
  function automatic int loc_of(input logic [31:0] addr);
    if ((addr >= `RAM_BASE) && (addr < `RAM_BASE + 4 * `RAM_WORDS))
      return int'((addr - `RAM_BASE) >> 2);
    else if (addr[31:14] == 18'h3FFFF)
      return int'(addr[13:2]);
    else
      return `RAM_WORDS + int'(addr[5:2]);
  endfunction

  // Appends a row and updates the model for writes
  function automatic void add_row(input string name, input int port, input bit wr,
                                  input bit dbg, input logic [31:0] daddr,
                                  input logic [31:0] iaddr, input bit fault, input int lat);
    int k;
    k = nrows;
    row_name[k]   = name;
    row_port[k]   = port;
    row_wr[k]     = wr;
    row_dbg[k]    = dbg;
    row_daddr[k]  = daddr;
    row_iaddr[k]  = iaddr;
    row_fault[k]  = fault;
    row_lat[k]    = lat;
    row_wdata[k]  = wr ? xorshift32() : 32'h0;
    row_tohost[k] = wr && (daddr == `TOHOST_ADDR);
    row_apb[k]    = dbg && (port != P_INST) && (daddr >= `DBG_START) && (daddr <= `DBG_END);
    if (wr && !fault && !row_tohost[k])
      model[loc_of(daddr)] = row_wdata[k];
    row_exp_d[k] = (!wr && !fault && (port != P_INST)) ? model[loc_of(daddr)] : 32'h0;
    row_exp_i[k] = (!fault && (port != P_DATA)) ? model[loc_of(iaddr)] : 32'h0;
    nrows = nrows + 1;
  endfunction

  // Compares one value and prints an error line on mismatch
  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks = checks + 1;
    assert (got === exp)
    else
    begin
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
      row_errs = row_errs + 1;
    end
  endtask

  // ========================================
  // One table row is driven, held until answered and checked
  // ========================================
  task automatic run_row(input int k);
    int   lat;
    int   d_lat;
    int   i_lat;
    bit   d_done;
    bit   i_done;
    logic [31:0] d_data;
    logic [31:0] i_data;
    logic d_flt;
    logic i_flt;
    row_errs = 0;
    lat      = 0;
    d_lat    = -1;
    i_lat    = -1;
    d_done   = (row_port[k] == P_INST);
    i_done   = (row_port[k] == P_DATA);
    @(posedge clk);
    i_debug_mode <= row_dbg[k];
    if (row_port[k] != P_INST)
    begin
      i_dmem_addr   <= row_daddr[k];
      i_dmem_wdata  <= row_wdata[k];
      i_dmem_wvalid <= row_wr[k];
      i_dmem_rready <= !row_wr[k];
    end
    if (row_port[k] != P_DATA)
    begin
      i_imem_addr   <= row_iaddr[k];
      i_imem_rready <= 1'b1;
    end
    // Sample mid-cycle and release each side on the edge after its answer
    while (!(d_done && i_done))
    begin
      @(negedge clk);
      if (!d_done && (row_wr[k] ? o_dmem_wready : o_dmem_rvalid))
      begin
        d_done = 1'b1;
        d_lat  = lat;
        d_data = o_dmem_rdata;
        d_flt  = o_dmem_fault;
      end
      if (!i_done && o_imem_rvalid)
      begin
        i_done = 1'b1;
        i_lat  = lat;
        i_data = o_imem_rdata;
        i_flt  = o_imem_fault;
      end
      @(posedge clk);
      if (d_done)
      begin
        i_dmem_rready <= 1'b0;
        i_dmem_wvalid <= 1'b0;
      end
      if (i_done)
        i_imem_rready <= 1'b0;
      lat = lat + 1;
    end
    if (row_port[k] != P_INST)
    begin
      if (!row_wr[k])
        check_word("o_dmem_rdata", d_data, row_exp_d[k]);
      check_word("o_dmem_fault", d_flt, row_fault[k]);
      if (row_lat[k] >= 0)
        check_word("data response latency", d_lat, row_lat[k]);
    end
    if (row_port[k] != P_DATA)
    begin
      check_word("o_imem_rdata", i_data, row_exp_i[k]);
      check_word("o_imem_fault", i_flt, row_fault[k]);
      if (row_lat[k] >= 0)
        check_word("fetch response latency", i_lat, row_lat[k]);
    end
    // Data read has the higher priority
    if (row_port[k] == P_BOTH)
    begin
      checks = checks + 1;
      assert (d_lat < i_lat)
      else
      begin
        $display("Data read did not finish before the fetch issued with it");
        row_errs = row_errs + 1;
      end
    end
    if (row_apb[k])
    begin
      check_word("o_apb_paddr", last_paddr, row_daddr[k][12:0]);
      check_word("o_apb_pwrite", last_pwrite, row_wr[k]);
      if (row_wr[k])
        check_word("o_apb_pwdata", last_pwdata, row_wdata[k]);
    end
    if (row_tohost[k])
    begin
      @(negedge clk);
      check_word("o_tohost", o_tohost, row_wdata[k]);
    end
    $display("test %0d %s: %0d errors", k + 1, row_name[k], row_errs);
    total_errs = total_errs + row_errs;
  endtask

  // ========================================
  // APB slave with two wait states per transfer
  // ========================================
  always @(posedge clk)
  begin
    if (o_apb_psel && !o_apb_penable)
    begin
      setup_seen   <= 1'b1;
      wait_cnt     <= 0;
      i_apb_pready <= 1'b0;
    end
    else if (o_apb_psel && o_apb_penable)
    begin
      assert (setup_seen)
      else
      begin
        $display("APB enable phase at %0t without a setup phase before it", $time);
        apb_errs = apb_errs + 1;
      end
      if (i_apb_pready)
      begin
        last_paddr  <= o_apb_paddr;
        last_pwrite <= o_apb_pwrite;
        if (o_apb_pwrite)
        begin
          apb_mem[o_apb_paddr[5:2]] <= o_apb_pwdata;
          last_pwdata <= o_apb_pwdata;
        end
        i_apb_pready <= 1'b0;
        setup_seen   <= 1'b0;
      end
      else if (wait_cnt == 1)
      begin
        i_apb_pready <= 1'b1;
        i_apb_prdata <= apb_mem[o_apb_paddr[5:2]];
      end
      else
        wait_cnt <= wait_cnt + 1;
    end
  end

  // Run limit from the table length
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= limit)
    begin
      $display("Timeout: no end of run within %0d cycles", limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial
  begin
    i_debug_mode  = 1'b0;
    i_imem_rready = 1'b0;
    i_imem_addr   = 32'h0;
    i_dmem_rready = 1'b0;
    i_dmem_wvalid = 1'b0;
    i_dmem_addr   = 32'h0;
    i_dmem_wdata  = 32'h0;
    i_apb_pready  = 1'b0;
    i_apb_prdata  = 32'h0;
    setup_seen    = 1'b0;
    wait_cnt      = 0;
    last_paddr    = '0;
    last_pwrite   = 1'b0;
    last_pwdata   = '0;
    checks        = 0;
    total_errs    = 0;
    apb_errs      = 0;
    cycle_cnt     = 0;
    nrows         = 0;
    rng_state     = 32'd5;
    for (int i = 0; i < `RAM_WORDS; i++)
      model[i] = 32'h0;
    // Slave fill carries its full word index
    for (int i = 0; i < 16; i++)
    begin
      apb_mem[i]               = 32'hDB00_0000 + i;
      model[`RAM_WORDS + i] = 32'hDB00_0000 + i;
    end
    add_row("ram write", P_DATA, 1, 0, 32'h0001_0010, 32'h0, 0, 0);
    add_row("ram read", P_DATA, 0, 0, 32'h0001_0010, 32'h0, 0, 2);
    add_row("alias read", P_DATA, 0, 0, 32'hFFFF_C010, 32'h0, 0, 2);
    add_row("fetch", P_INST, 0, 0, 32'h0, 32'h0001_0010, 0, 2);
    add_row("ram write 2", P_DATA, 1, 0, 32'h0001_0024, 32'h0, 0, 0);
    add_row("debug write", P_DATA, 1, 1, 32'h0000_0300, 32'h0, 0, 5);
    add_row("debug read", P_DATA, 0, 1, 32'h0000_0300, 32'h0, 0, 5);
    add_row("debug outside mode", P_DATA, 0, 0, 32'h0000_0300, 32'h0, 1, 1);
    add_row("unmapped read", P_DATA, 0, 0, 32'h0002_0000, 32'h0, 1, 1);
    add_row("fetch from debug", P_INST, 0, 1, 32'h0, 32'h0000_0300, 1, 1);
    add_row("tohost write", P_DATA, 1, 0, `TOHOST_ADDR, 32'h0, 0, 0);
    add_row("fetch with read", P_BOTH, 0, 0, 32'h0001_0024, 32'h0001_0010, 0, -1);
    limit = nrows * 12 + RESET_CYCLES;

    @(posedge reset_n);
    @(negedge clk);
    // Outputs idle straight out of reset
    row_errs = 0;
    check_word("o_apb_psel", o_apb_psel, 1'b0);
    check_word("o_apb_penable", o_apb_penable, 1'b0);
    check_word("o_imem_rvalid", o_imem_rvalid, 1'b0);
    check_word("o_dmem_rvalid", o_dmem_rvalid, 1'b0);
    check_word("o_dmem_wready", o_dmem_wready, 1'b0);
    check_word("o_imem_fault", o_imem_fault, 1'b0);
    check_word("o_dmem_fault", o_dmem_fault, 1'b0);
    check_word("o_tohost", o_tohost, 32'h0);
    $display("test 0 reset values: %0d errors", row_errs);
    total_errs = total_errs + row_errs;

    for (int k = 0; k < nrows; k++)
      run_row(k);

    total_errs = total_errs + apb_errs;
    $display("Tests: %0d, checks: %0d, errors: %0d", nrows + 1, checks, total_errs);
    if (total_errs == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- tb.f
+incdir+hw
hw/mem_map_pkg.sv
hw/mem_map_ifs.sv
hw/mem_req_decode.sv
hw/shared_ram.sv
hw/debug_apb_master.sv
hw/core_resp_unit.sv
hw/mem_subsys_top.sv
tb/tb_clk_gen.sv
tb/tb_mem_subsys.sv
